/* src/uart_frame_pkg.sv */
package uart_frame_pkg;

	// serial line levels
	localparam logic IDLE_LEVEL  = 1'b1; // line rests high between frames
	localparam logic START_LEVEL = 1'b0; // start bit pulls the line low
	localparam logic STOP_LEVEL  = 1'b1; // stop bit returns it high

	// parity selection, used as the PARITY_ODD module parameter
	localparam logic PARITY_EVEN = 1'b0; // parity bit makes the count of ones even
	localparam logic PARITY_ODD  = 1'b1; // parity bit makes the count of ones odd

	// frame on the wire, LSB first:
	//   start | data[0] .. data[DATA_WIDTH-1] | parity (optional) | stop
	// every bit is held for CLKS_PER_BIT cycles of tx_clk

	// the frame length depends on module parameters, so each module
	// works out FRAME_BITS = 2 + DATA_WIDTH + PARITY_ENABLED itself

endpackage

/* src/uart_rx_pkg.sv */
package uart_rx_pkg;

	// receiver FSM state register width
	localparam int RX_STATE_W = 3;

	// receiver FSM states
	localparam logic [RX_STATE_W-1:0] RX_IDLE   = 3'd0; // waiting for a falling edge
	localparam logic [RX_STATE_W-1:0] RX_START  = 3'd1; // half-bit wait, start bit recheck
	localparam logic [RX_STATE_W-1:0] RX_DATA   = 3'd2; // data bits, LSB first
	localparam logic [RX_STATE_W-1:0] RX_PARITY = 3'd3; // parity bit, only with parity on
	localparam logic [RX_STATE_W-1:0] RX_STOP   = 3'd4; // stop bit and frame verdict

	// the remaining codes 5..7 are unused and fall back to RX_IDLE

	// flops between the line pin and the sampler
	// the line can come from outside the chip, so it is treated as async
	localparam int SYNC_STAGES = 3;

	// a line edge shows up in the FSM SYNC_STAGES cycles after it hits the pin
	// plus one more for the edge detect register, so rx pulses trail the
	// transmitted bit by that much in loopback

endpackage

/* src/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
	parameter int DATA_WIDTH     = 8,
	parameter int PARITY_ENABLED = 1,
	parameter bit PARITY_ODD     = uart_frame_pkg::PARITY_EVEN,
	parameter int CLKS_PER_BIT   = 8
) (
	input  logic                  i_tx_clk,
	input  logic                  i_reset_tx,
	input  logic                  i_enable,     // word request, taken only while idle
	input  logic [DATA_WIDTH-1:0] i_data,       // word to send, sampled on acceptance
	output logic                  o_busy,       // high for the whole frame
	output logic                  o_serial_out  // serial line, idle high
);

	localparam int FRAME_BITS = 2 + DATA_WIDTH + PARITY_ENABLED; // start, data, parity, stop
	localparam int BODY_BITS  = FRAME_BITS - 1;                  // all bits after the start bit
	localparam int TIMER_W    = $clog2(CLKS_PER_BIT);            // bit timer width
	localparam int COUNT_W    = $clog2(FRAME_BITS + 1);          // holds FRAME_BITS down to 0

	logic [TIMER_W-1:0]   timer_q;     // cycle within the current bit
	logic [COUNT_W-1:0]   bits_left_q; // bits still on their way out, 0 = idle
	logic [BODY_BITS-1:0] shift_q;     // bits queued behind the one on the line
	logic [BODY_BITS-1:0] body;        // stop, parity and data built from i_data
	logic                 serial_q;    // registered line driver
	logic                 accept;      // word taken this cycle
	logic                 bit_end;     // last cycle of the current bit

	// handshake: enable only counts while the transmitter is free
	assign accept   = i_enable && !o_busy;

	// the timer wraps once per bit, boundaries only matter mid-frame
	assign bit_end  = o_busy && (timer_q == TIMER_W'(CLKS_PER_BIT - 1));

	// frame body, the start bit goes straight to serial_q on acceptance
	generate
		if (PARITY_ENABLED != 0) begin : g_parity
			logic parity_bit; // xor of the data, flipped for odd parity

			assign parity_bit = (^i_data) ^ (PARITY_ODD == uart_frame_pkg::PARITY_ODD);
			assign body       = {uart_frame_pkg::STOP_LEVEL, parity_bit, i_data};
		end else begin : g_no_parity
			assign body = {uart_frame_pkg::STOP_LEVEL, i_data}; // data then stop
		end
	endgenerate

	// bit timer, restarts on every acceptance so the start bit is full length
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			timer_q <= '0;
		end else if (accept || bit_end) begin
			timer_q <= '0; // new frame or new bit
		end else if (o_busy) begin
			timer_q <= timer_q + 1'b1;
		end
	end

	// bit counter, busy is simply "bits left"
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			bits_left_q <= '0;
		end else if (accept) begin
			bits_left_q <= COUNT_W'(FRAME_BITS); // start bit is already counted
		end else if (bit_end) begin
			bits_left_q <= bits_left_q - 1'b1; // reaches 0 after the stop bit
		end
	end

	// frame shift register, shifts toward bit 0 at each boundary
	// idle level fills in from the top so the tail is always high
	always_ff @(posedge i_tx_clk) begin
		if (accept) begin
			shift_q <= body;
		end else if (bit_end) begin
			shift_q <= {uart_frame_pkg::IDLE_LEVEL, shift_q[BODY_BITS-1:1]};
		end
	end

	// line driver
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			serial_q <= uart_frame_pkg::IDLE_LEVEL;
		end else if (accept) begin
			serial_q <= uart_frame_pkg::START_LEVEL; // start bit in the cycle after acceptance
		end else if (bit_end) begin
			serial_q <= shift_q[0]; // next bit, idle fill once the stop bit is done
		end
	end

	assign o_busy       = (bits_left_q != '0);
	assign o_serial_out = serial_q;

	// frame timeline, with t the acceptance edge:
	//   busy and start bit from t+1
	//   data bit i from t+1+(i+1)*CLKS_PER_BIT
	//   busy drops at the edge that ends the stop bit, t+FRAME_BITS*CLKS_PER_BIT
	//   a waiting enable is taken in the first idle cycle after that

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
	parameter int DATA_WIDTH     = 8,
	parameter int PARITY_ENABLED = 1,
	parameter bit PARITY_ODD     = uart_frame_pkg::PARITY_EVEN,
	parameter int CLKS_PER_BIT   = 8
) (
	input  logic                  i_tx_clk,
	input  logic                  i_reset_tx,
	input  logic                  i_line,   // serial line, async to the sampler
	output logic [DATA_WIDTH-1:0] o_data,   // last good word, held
	output logic                  o_valid,  // one-cycle pulse per good frame
	output logic                  o_error   // one-cycle pulse per bad frame
);

	localparam int FRAME_BITS = 2 + DATA_WIDTH + PARITY_ENABLED; // start, data, parity, stop
	localparam int HALF_BIT   = CLKS_PER_BIT / 2;                // edge to start bit centre
	localparam int CNT_W      = $clog2(CLKS_PER_BIT);            // sample counter width
	localparam int POS_W      = $clog2(FRAME_BITS);              // frame position width
	localparam int SYNC_N     = uart_rx_pkg::SYNC_STAGES;

	logic [SYNC_N-1:0]                 sync_q;      // synchronizer chain, bit 0 nearest the pin
	logic                              line_s;      // synced line
	logic                              line_d;      // synced line one cycle back
	logic                              line_fall;   // idle to start transition
	logic [uart_rx_pkg::RX_STATE_W-1:0] state_q;
	logic [CNT_W-1:0]                  cnt_q;       // cycles to the next sample point
	logic                              sample;      // this cycle is a sample point
	logic [POS_W-1:0]                  pos_q;       // frame position of the next sample
	logic [DATA_WIDTH-1:0]             shift_q;     // data being assembled, LSB first
	logic                              parity_ok_q; // parity bit matched, stays 1 without parity
	logic                              parity_exp;  // parity bit the data calls for
	logic                              stop_ok;     // stop bit at the right level

	// synchronizer, preset to idle so reset never looks like a start bit
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			sync_q <= {SYNC_N{uart_frame_pkg::IDLE_LEVEL}};
			line_d <= uart_frame_pkg::IDLE_LEVEL;
		end else begin
			sync_q <= {sync_q[SYNC_N-2:0], i_line}; // shift toward the top bit
			line_d <= line_s;
		end
	end

	assign line_s    = sync_q[SYNC_N-1];
	// an edge and not a level, a low stop bit must not look like a new start
	assign line_fall = (line_d == uart_frame_pkg::IDLE_LEVEL) &&
	                   (line_s == uart_frame_pkg::START_LEVEL);

	assign sample     = (cnt_q == '0);
	assign parity_exp = (^shift_q) ^ (PARITY_ODD == uart_frame_pkg::PARITY_ODD);
	assign stop_ok    = (line_s == uart_frame_pkg::STOP_LEVEL);

	// receive FSM
	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			state_q     <= uart_rx_pkg::RX_IDLE;
			cnt_q       <= '0;
			pos_q       <= '0;
			parity_ok_q <= 1'b1;
			o_valid     <= 1'b0;
			o_error     <= 1'b0;
			o_data      <= '0;
		end else begin
			o_valid <= 1'b0; // pulses last one cycle
			o_error <= 1'b0;

			// one full bit between samples once the start bit is found
			if (state_q != uart_rx_pkg::RX_IDLE) begin
				if (sample) begin
					cnt_q <= CNT_W'(CLKS_PER_BIT - 1);
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
			end

			case (state_q)
				uart_rx_pkg::RX_IDLE: begin
					if (line_fall) begin
						state_q     <= uart_rx_pkg::RX_START;
						cnt_q       <= CNT_W'(HALF_BIT - 1); // land mid start bit
						pos_q       <= POS_W'(1);            // first data bit next
						parity_ok_q <= 1'b1;
					end
				end
				uart_rx_pkg::RX_START: begin
					if (sample) begin
						if (line_s == uart_frame_pkg::START_LEVEL) begin
							state_q <= uart_rx_pkg::RX_DATA;
						end else begin
							state_q <= uart_rx_pkg::RX_IDLE; // glitch, drop quietly
						end
					end
				end
				uart_rx_pkg::RX_DATA: begin
					if (sample) begin
						pos_q <= pos_q + 1'b1;
						if (pos_q == POS_W'(DATA_WIDTH)) begin // last data bit
							if (PARITY_ENABLED != 0) begin
								state_q <= uart_rx_pkg::RX_PARITY;
							end else begin
								state_q <= uart_rx_pkg::RX_STOP;
							end
						end
					end
				end
				uart_rx_pkg::RX_PARITY: begin
					if (sample) begin
						parity_ok_q <= (line_s == parity_exp);
						state_q     <= uart_rx_pkg::RX_STOP;
					end
				end
				uart_rx_pkg::RX_STOP: begin
					if (sample) begin
						state_q <= uart_rx_pkg::RX_IDLE;
						if (stop_ok && parity_ok_q) begin
							o_valid <= 1'b1;
							o_data  <= shift_q; // output only moves on a good frame
						end else begin
							o_error <= 1'b1;
						end
					end
				end
				default: begin
					state_q <= uart_rx_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// data shifter, new bits enter at the top so bit 0 ends up as the first one sent
	always_ff @(posedge i_tx_clk) begin
		if ((state_q == uart_rx_pkg::RX_DATA) && sample) begin
			shift_q <= {line_s, shift_q[DATA_WIDTH-1:1]};
		end
	end

endmodule

/* src/uart_loopback_top.sv */
`timescale 1ns/1ps

module uart_loopback_top #(
	parameter int DATA_WIDTH     = 8,
	parameter int PARITY_ENABLED = 1,                           // 0 drops the parity bit
	parameter bit PARITY_ODD     = uart_frame_pkg::PARITY_EVEN, // even parity by default
	parameter int CLKS_PER_BIT   = 8                            // tx_clk cycles per bit
) (
	input  logic                  tx_clk,
	input  logic                  reset_tx,
	input  logic                  i_tx_enable,
	input  logic [DATA_WIDTH-1:0] i_tx_data,
	input  logic                  i_loopback,  // 1 = rx listens to our own tx line
	input  logic                  i_serial_in, // external rx line
	output logic                  o_tx_busy,
	output logic                  o_serial_out,
	output logic [DATA_WIDTH-1:0] o_rx_data,
	output logic                  o_rx_valid,
	output logic                  o_rx_error
);

	logic rx_line; // line seen by the receiver

	// the sampler needs a half bit of at least two cycles
	if (CLKS_PER_BIT < 4) begin : g_bad_clks_per_bit
		$error("uart_loopback_top: CLKS_PER_BIT must be at least 4");
	end

	uart_tx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.PARITY_ENABLED (PARITY_ENABLED),
		.PARITY_ODD     (PARITY_ODD),
		.CLKS_PER_BIT   (CLKS_PER_BIT)
	) u_tx (
		.i_tx_clk     (tx_clk),
		.i_reset_tx   (reset_tx),
		.i_enable     (i_tx_enable),
		.i_data       (i_tx_data),
		.o_busy       (o_tx_busy),
		.o_serial_out (o_serial_out)
	);

	// switch only while both lines idle, or rx sees a false edge
	assign rx_line = i_loopback ? o_serial_out : i_serial_in;

	uart_rx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.PARITY_ENABLED (PARITY_ENABLED),
		.PARITY_ODD     (PARITY_ODD),
		.CLKS_PER_BIT   (CLKS_PER_BIT)
	) u_rx (
		.i_tx_clk   (tx_clk),
		.i_reset_tx (reset_tx),
		.i_line     (rx_line),
		.o_data     (o_rx_data),
		.o_valid    (o_rx_valid),
		.o_error    (o_rx_error)
	);

endmodule

/* tests/uart_sva.sv */
`timescale 1ns/1ps

module uart_sva (
	input logic i_clk,
	input logic i_reset,
	input logic i_tx_busy,
	input logic i_serial_out,
	input logic i_rx_valid,
	input logic i_rx_error
);

	int fail_count = 0; // assertion failures so far

	// a frame is either good or bad, never both
	a_valid_error_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_rx_valid && i_rx_error))
		else begin
			fail_count++;
			$error("o_rx_valid and o_rx_error high in the same cycle");
		end

	// receiver verdicts are single-cycle pulses
	a_valid_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
		i_rx_valid |=> !i_rx_valid)
		else begin
			fail_count++;
			$error("o_rx_valid held for more than one cycle");
		end

	a_error_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
		i_rx_error |=> !i_rx_error)
		else begin
			fail_count++;
			$error("o_rx_error held for more than one cycle");
		end

	// line rests at idle level whenever no frame is in flight
	a_idle_when_free: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_tx_busy |-> (i_serial_out == uart_frame_pkg::IDLE_LEVEL))
		else begin
			fail_count++;
			$error("o_serial_out not idle while o_tx_busy is low");
		end

endmodule

bind uart_loopback_top uart_sva u_uart_sva (
	.i_clk        (tx_clk),
	.i_reset      (reset_tx),
	.i_tx_busy    (o_tx_busy),
	.i_serial_out (o_serial_out),
	.i_rx_valid   (o_rx_valid),
	.i_rx_error   (o_rx_error)
);

/* tests/tb_uart_loopback.sv */
`timescale 1ns/1ps

module tb_uart_loopback;

	localparam int DATA_WIDTH     = 8;                           // dut defaults
	localparam int PARITY_ENABLED = 1;
	localparam bit ODD_PARITY     = uart_frame_pkg::PARITY_EVEN;
	localparam int CLKS_PER_BIT   = 8;
	localparam int FRAME_BITS     = 2 + DATA_WIDTH + PARITY_ENABLED;
	localparam int FRAME_CYCLES   = FRAME_BITS * CLKS_PER_BIT;   // busy length per frame
	localparam int RESET_CYCLES   = 5;
	localparam int LOOP_WORDS     = 200;
	localparam int NUM_FRAMES     = 4 + LOOP_WORDS + 1 + 3 + 1;  // all frames of all tests
	localparam int TIMEOUT_CYCLES = (3 * NUM_FRAMES * (FRAME_BITS + 4) * CLKS_PER_BIT) / 2
	                                + RESET_CYCLES;
	localparam int DRAIN_LIMIT    = 3 * FRAME_CYCLES;            // per wait, in cycles

	logic                  tx_clk;
	logic                  reset_tx;
	logic                  i_tx_enable;
	logic [DATA_WIDTH-1:0] i_tx_data;
	logic                  i_loopback;
	logic                  i_serial_in;
	logic                  o_tx_busy;
	logic                  o_serial_out;
	logic [DATA_WIDTH-1:0] o_rx_data;
	logic                  o_rx_valid;
	logic                  o_rx_error;

	logic [DATA_WIDTH-1:0] rx_q[$];       // words the receiver still owes
	logic [DATA_WIDTH-1:0] line_q[$];     // words the tx line still owes
	logic [31:0]           lfsr_state = 32'h014d_0b0a;
	int                    error_count;
	int                    test_errors;   // error_count at test start
	int                    cycle_count;
	int                    rx_valid_count;
	int                    rx_error_count;
	int                    frames_decoded;
	int                    busy_frames;
	int                    busy_len;       // cycles of the current busy stretch
	logic                  line_prev;
	logic [DATA_WIDTH-1:0] expected_rx;
	logic [DATA_WIDTH-1:0] held_data;
	logic [DATA_WIDTH-1:0] word;
	logic [31:0]           rnd;
	int                    v0, e0, f0, b0;

	uart_loopback_top u_uart_loopback_top (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_tx_enable  (i_tx_enable),
		.i_tx_data    (i_tx_data),
		.i_loopback   (i_loopback),
		.i_serial_in  (i_serial_in),
		.o_tx_busy    (o_tx_busy),
		.o_serial_out (o_serial_out),
		.o_rx_data    (o_rx_data),
		.o_rx_valid   (o_rx_valid),
		.o_rx_error   (o_rx_error)
	);

	initial begin
		tx_clk = 1'b0;
		forever #4 tx_clk = ~tx_clk; // 8 ns period
	end

	// 32-bit fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic report_problem(input string msg);
		$display("at %0t ns something went wrong: %s", $time, msg);
		error_count++;
	endtask

	task automatic end_test(input string name);
		$display("%-28s %s, %0d errors", name,
		         (error_count == test_errors) ? "passed" : "failed", error_count - test_errors);
		test_errors = error_count;
	endtask

	// all stimulus tasks start and end 1 ns after a rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge tx_clk);
		#1;
	endtask

	// hold enable until the transmitter is free, acceptance on the next edge
	task automatic send_word(input logic [DATA_WIDTH-1:0] w);
		i_tx_enable = 1'b1;
		i_tx_data   = w;
		@(negedge tx_clk);
		while (o_tx_busy) @(negedge tx_clk);
		@(posedge tx_clk);
		#1;
		i_tx_enable = 1'b0;
	endtask

	task automatic wait_tx_idle();
		@(negedge tx_clk);
		while (o_tx_busy) @(negedge tx_clk);
		@(posedge tx_clk);
		#1;
	endtask

	task automatic drain_queues();
		int waited;
		waited = 0;
		@(negedge tx_clk);
		while ((o_tx_busy || rx_q.size() != 0 || line_q.size() != 0) && waited < DRAIN_LIMIT) begin
			@(negedge tx_clk);
			waited++;
		end
		if (waited >= DRAIN_LIMIT)
			report_problem("expected words were not delivered in time");
		@(posedge tx_clk);
		#1;
	endtask

	// waits for any receiver pulse after the given total
	task automatic wait_rx_event(input int total_before);
		int waited;
		waited = 0;
		while (rx_valid_count + rx_error_count == total_before && waited < DRAIN_LIMIT) begin
			@(negedge tx_clk);
			waited++;
		end
		if (waited >= DRAIN_LIMIT)
			report_problem("receiver gave no pulse for an external frame");
		@(posedge tx_clk);
		#1;
	endtask

	task automatic drive_line_bit(input logic b);
		i_serial_in = b;
		wait_cycles(CLKS_PER_BIT);
	endtask

	// external frame, parity flip and stop level let it be corrupted
	task automatic drive_ext_frame(input logic [DATA_WIDTH-1:0] w, input logic flip_parity,
	                               input logic stop_bit);
		logic parity_bit;
		parity_bit = (^w) ^ ODD_PARITY ^ flip_parity;
		drive_line_bit(uart_frame_pkg::START_LEVEL);
		for (int i = 0; i < DATA_WIDTH; i++) begin
			drive_line_bit(w[i]); // lsb first
		end
		if (PARITY_ENABLED != 0) begin
			drive_line_bit(parity_bit);
		end
		drive_line_bit(stop_bit);
		drive_line_bit(uart_frame_pkg::IDLE_LEVEL);
		drive_line_bit(uart_frame_pkg::IDLE_LEVEL);
	endtask

	// decodes one frame from the tx line, entered in the first start cycle
	task automatic decode_frame();
		logic [DATA_WIDTH-1:0] w;
		logic [DATA_WIDTH-1:0] expected;
		logic                  parity_bit;
		w = '0;
		repeat (CLKS_PER_BIT / 2) @(negedge tx_clk); // centre of the start bit
		assert (o_serial_out == uart_frame_pkg::START_LEVEL)
			else report_mismatch("start bit not low at mid-bit");
		for (int i = 0; i < DATA_WIDTH; i++) begin
			repeat (CLKS_PER_BIT) @(negedge tx_clk);
			w[i] = o_serial_out;
		end
		if (PARITY_ENABLED != 0) begin
			repeat (CLKS_PER_BIT) @(negedge tx_clk);
			parity_bit = o_serial_out;
			assert (((^w) ^ parity_bit) == ODD_PARITY)
				else report_mismatch($sformatf("wrong parity bit %0b for data %h", parity_bit, w));
		end
		repeat (CLKS_PER_BIT) @(negedge tx_clk);
		assert (o_serial_out == uart_frame_pkg::STOP_LEVEL)
			else report_mismatch("stop bit not high at mid-bit");
		if (line_q.size() == 0) begin
			report_problem("frame on o_serial_out without an accepted word");
		end else begin
			expected = line_q.pop_front();
			assert (w == expected)
				else report_mismatch($sformatf("line data %h, expected %h", w, expected));
		end
		frames_decoded++;
	endtask

	// line decoder, looks for a falling edge on the tx line
	initial begin
		line_prev = uart_frame_pkg::IDLE_LEVEL;
		forever begin
			@(negedge tx_clk);
			if (!reset_tx && line_prev && (o_serial_out == uart_frame_pkg::START_LEVEL))
				decode_frame();
			line_prev = o_serial_out;
		end
	end

	// acceptance, busy length and receiver monitors, all sampled mid-cycle
	always @(negedge tx_clk) begin
		if (!reset_tx) begin
			if (i_tx_enable && !o_tx_busy) begin // taken at the next rising edge
				line_q.push_back(i_tx_data);
				if (i_loopback)
					rx_q.push_back(i_tx_data);
			end
			if (o_tx_busy) begin
				busy_len++;
			end else if (busy_len != 0) begin
				assert (busy_len == FRAME_CYCLES)
					else report_mismatch($sformatf("busy for %0d cycles, expected %0d",
					                               busy_len, FRAME_CYCLES));
				busy_frames++;
				busy_len = 0;
			end
			if (o_rx_valid) begin
				rx_valid_count++;
				if (rx_q.size() == 0) begin
					report_problem("o_rx_valid pulse with no word outstanding");
				end else begin
					expected_rx = rx_q.pop_front();
					assert (o_rx_data == expected_rx)
						else report_mismatch($sformatf("o_rx_data %h, expected %h",
						                               o_rx_data, expected_rx));
				end
			end
			if (o_rx_error)
				rx_error_count++;
		end
	end

	// run limit
	always @(posedge tx_clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		reset_tx    = 1'b1;
		i_tx_enable = 1'b0;
		i_tx_data   = '0;
		i_loopback  = 1'b1;
		i_serial_in = uart_frame_pkg::IDLE_LEVEL;
		repeat (RESET_CYCLES) @(posedge tx_clk);
		#1;
		reset_tx = 1'b0;

		// 1. quiet after reset
		assert (o_tx_busy === 1'b0) else report_mismatch("o_tx_busy not low after reset");
		assert (o_serial_out === uart_frame_pkg::IDLE_LEVEL)
			else report_mismatch("o_serial_out not idle after reset");
		wait_cycles(2 * CLKS_PER_BIT);
		assert (rx_valid_count == 0 && rx_error_count == 0)
			else report_mismatch("receiver pulse before any frame");
		end_test("reset state");

		// 2. frame format, a few words with a one-bit gap
		f0 = frames_decoded;
		b0 = busy_frames;
		for (int n = 0; n < 4; n++) begin
			random_bits(DATA_WIDTH, rnd);
			send_word(rnd[DATA_WIDTH-1:0]);
			wait_tx_idle();
			wait_cycles(CLKS_PER_BIT);
		end
		drain_queues();
		assert (frames_decoded - f0 == 4 && busy_frames - b0 == 4)
			else report_mismatch("frame format test did not see 4 frames");
		end_test("frame format");

		// 3. random loopback traffic, gap 0 gives back-to-back frames
		v0 = rx_valid_count;
		e0 = rx_error_count;
		for (int n = 0; n < LOOP_WORDS; n++) begin
			random_bits(DATA_WIDTH, rnd);
			word = rnd[DATA_WIDTH-1:0];
			random_bits(2, rnd);
			if (rnd[1:0] != 0) begin
				wait_tx_idle();
				wait_cycles(rnd[1:0] * CLKS_PER_BIT);
			end
			send_word(word);
		end
		drain_queues();
		assert (rx_valid_count - v0 == LOOP_WORDS && rx_error_count == e0 && rx_q.size() == 0)
			else report_mismatch("loopback counts or queue wrong after random traffic");
		end_test("random loopback");

		// 4. enable raised mid-frame with other data
		v0 = rx_valid_count;
		random_bits(DATA_WIDTH, rnd);
		word = rnd[DATA_WIDTH-1:0];
		send_word(word);
		wait_cycles(FRAME_CYCLES / 2);
		i_tx_enable = 1'b1;
		i_tx_data   = ~word;
		wait_cycles(2);
		i_tx_enable = 1'b0;
		drain_queues();
		assert (rx_valid_count - v0 == 1 && o_rx_data == word)
			else report_mismatch("enable while busy changed what was sent");
		end_test("enable while busy");

		// 5. external frames with bad parity and low stop
		i_loopback = 1'b0; // both lines idle here
		wait_cycles(CLKS_PER_BIT);
		held_data = o_rx_data;
		for (int k = 0; k < 2; k++) begin
			v0 = rx_valid_count;
			e0 = rx_error_count;
			random_bits(DATA_WIDTH, rnd);
			if (k == 0)
				drive_ext_frame(rnd[DATA_WIDTH-1:0], 1'b1, uart_frame_pkg::STOP_LEVEL);
			else
				drive_ext_frame(rnd[DATA_WIDTH-1:0], 1'b0, uart_frame_pkg::START_LEVEL);
			wait_rx_event(v0 + e0);
			assert (rx_error_count - e0 == 1 && rx_valid_count == v0 && o_rx_data == held_data)
				else report_mismatch($sformatf("bad frame %0d not flagged as one error", k));
		end
		v0 = rx_valid_count;
		random_bits(DATA_WIDTH, rnd);
		rx_q.push_back(rnd[DATA_WIDTH-1:0]);
		drive_ext_frame(rnd[DATA_WIDTH-1:0], 1'b0, uart_frame_pkg::STOP_LEVEL);
		wait_rx_event(v0 + rx_error_count);
		assert (rx_valid_count - v0 == 1 && rx_q.size() == 0)
			else report_mismatch("good frame after error frames not received");
		end_test("external error frames");

		// 6. short low glitch on the external line
		v0 = rx_valid_count;
		e0 = rx_error_count;
		i_serial_in = uart_frame_pkg::START_LEVEL;
		wait_cycles(CLKS_PER_BIT / 4);
		i_serial_in = uart_frame_pkg::IDLE_LEVEL;
		wait_cycles(FRAME_CYCLES + 2 * CLKS_PER_BIT); // a false start would have ended by now
		assert (rx_valid_count == v0 && rx_error_count == e0)
			else report_mismatch("glitch produced a receiver pulse");
		random_bits(DATA_WIDTH, rnd);
		rx_q.push_back(rnd[DATA_WIDTH-1:0]);
		drive_ext_frame(rnd[DATA_WIDTH-1:0], 1'b0, uart_frame_pkg::STOP_LEVEL);
		wait_rx_event(v0 + e0);
		assert (rx_valid_count - v0 == 1 && rx_error_count == e0 && rx_q.size() == 0)
			else report_mismatch("frame after glitch not received");
		end_test("glitch rejection");

		assert (u_uart_loopback_top.u_uart_sva.fail_count == 0)
			else report_problem("a concurrent assertion on the DUT ports failed");

		$display("summary: %0d errors, %0d frames decoded, %0d words received, %0d rx errors",
		         error_count, frames_decoded, rx_valid_count, rx_error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
src/uart_frame_pkg.sv
src/uart_rx_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_loopback_top.sv
tests/uart_sva.sv
tests/tb_uart_loopback.sv
